//--- hsv_issue.f
+incdir+design
design/hsv_core_pkg.sv
design/hs_skid_buffer.sv
design/hsv_core_regfile.sv
design/hsv_core_issue_hazardmask.sv
design/hsv_core_issue_fork.sv
design/hsv_core_issue.sv
verification/hsv_issue_checker.sv
verification/tb_hsv_core_issue.sv

//--- Makefile
.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f hsv_issue.f --top-module tb_hsv_core_issue
	verilator --lint-only -f hsv_issue.f design/hsv_core_issue.sv --top-module hsv_core_issue

sim:
	verilator --binary --timing -f hsv_issue.f --top-module tb_hsv_core_issue -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -F -q "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verification/tb_hsv_core_issue.sv
`timescale 1ns/1ps

module tb_hsv_core_issue;

  logic clk_core;
  logic rst_core_n;
  logic flush_req;
  logic flush_ack;
  logic valid;
  logic ready;
  logic alu_valid, alu_ready, mem_valid, mem_ready, branch_valid, branch_ready;
  logic consumers_on;
  logic accept;
  hsv_core_pkg::issue_data_t  instr;
  hsv_core_pkg::alu_data_t    alu_data, exp_alu;
  hsv_core_pkg::mem_data_t    mem_data, exp_mem;
  hsv_core_pkg::branch_data_t branch_data, exp_branch;
  hsv_core_pkg::commit_t      commit;
  hsv_core_pkg::word_t        spec_val [32];
  hsv_core_pkg::word_t        committed_val [32];
  hsv_core_pkg::word_t        rs1_val, rs2_val;
  hsv_core_pkg::reg_addr_t    cq_rd [$];
  hsv_core_pkg::tag_t         cq_tag [$];
  hsv_core_pkg::tag_t         next_tag;
  integer seed;
  int tb_errors, chk_errors, pending, commit_delay;
  int hold [3];

  hsv_core_issue uut (
    .clk_core (clk_core), .rst_core_n (rst_core_n),
    .flush_req_i (flush_req), .flush_ack_o (flush_ack),
    .issue_data_i (instr), .valid_i (valid), .ready_o (ready),
    .alu_data_o (alu_data), .alu_valid_o (alu_valid), .alu_ready_i (alu_ready),
    .mem_data_o (mem_data), .mem_valid_o (mem_valid), .mem_ready_i (mem_ready),
    .branch_data_o (branch_data), .branch_valid_o (branch_valid),
    .branch_ready_i (branch_ready), .commit_i (commit)
  );

  hsv_issue_checker chk (
    .clk_core (clk_core), .rst_core_n (rst_core_n), .clear_i (flush_req),
    .alu_push_i (accept && instr.unit == hsv_core_pkg::UNIT_ALU), .alu_exp_i (exp_alu),
    .mem_push_i (accept && instr.unit == hsv_core_pkg::UNIT_MEM), .mem_exp_i (exp_mem),
    .branch_push_i (accept && instr.unit == hsv_core_pkg::UNIT_BRANCH),
    .branch_exp_i (exp_branch),
    .alu_data_i (alu_data), .alu_valid_i (alu_valid), .alu_ready_i (alu_ready),
    .mem_data_i (mem_data), .mem_valid_i (mem_valid), .mem_ready_i (mem_ready),
    .branch_data_i (branch_data), .branch_valid_i (branch_valid),
    .branch_ready_i (branch_ready), .error_count_o (chk_errors), .pending_o (pending)
  );

  // Result value that a unit would produce for a given tag
  function automatic hsv_core_pkg::word_t commit_value(hsv_core_pkg::tag_t t);
    return {24'h0, t} * 32'h0001_9e37 + 32'h11;
  endfunction

  initial begin
    clk_core = 1'b0;
    forever #10 clk_core = ~clk_core;
  end

  // Expected unit items follow from the newest older writer of each source
  assign accept  = rst_core_n & valid & ready;
  assign rs1_val = (instr.rs1 == '0) ? '0 : spec_val[instr.rs1];
  assign rs2_val = (instr.rs2 == '0) ? '0 : spec_val[instr.rs2];
  always_comb begin
    exp_alu    = '{instr.tag, instr.op.alu, instr.rd, rs1_val, rs2_val, instr.imm};
    exp_mem    = '{instr.tag, instr.op.mem, instr.rd, rs1_val, rs2_val, instr.imm};
    exp_branch = '{instr.tag, instr.op.alu, instr.rd, rs1_val, rs2_val, instr.imm};
  end

  // Reset and flush fall back to the committed state
  always @(posedge clk_core) begin
    if (!rst_core_n || flush_req) begin
      for (int i = 0; i < 32; i++) begin
        spec_val[i] <= committed_val[i];
      end
    end else if (accept && instr.rd != '0) begin
      spec_val[instr.rd] <= commit_value(instr.tag);
    end
  end

  always @(posedge clk_core) begin
    if (rst_core_n) begin
      if (alu_valid && alu_ready && alu_data.rd != '0) begin
        cq_rd.push_back(alu_data.rd);
        cq_tag.push_back(alu_data.tag);
      end
      if (mem_valid && mem_ready && mem_data.rd != '0) begin
        cq_rd.push_back(mem_data.rd);
        cq_tag.push_back(mem_data.tag);
      end
      if (branch_valid && branch_ready && branch_data.rd != '0) begin
        cq_rd.push_back(branch_data.rd);
        cq_tag.push_back(branch_data.tag);
      end
    end
  end

  always @(posedge clk_core) begin
    #2;
    commit = '0;
    if (commit_delay > 0) begin
      commit_delay--;
    end else if (cq_rd.size() > 0) begin
      commit.valid = 1'b1;
      commit.rd    = cq_rd.pop_front();
      commit.data  = commit_value(cq_tag.pop_front());
      committed_val[commit.rd] = commit.data;
      commit_delay = {$random(seed)} % 5;
    end
  end

  // Random ready with long stretches of back-pressure now and then
  task automatic pick_ready(int u, output logic rdy);
    if (hold[u] > 0) begin
      hold[u]--;
      rdy = 1'b0;
    end else if ({$random(seed)} % 40 == 0) begin
      hold[u] = 10 + {$random(seed)} % 40;
      rdy = 1'b0;
    end else begin
      rdy = ($random(seed) % 4) != 0;
    end
  endtask

  always @(posedge clk_core) begin
    #2;
    pick_ready(0, alu_ready);
    pick_ready(1, mem_ready);
    pick_ready(2, branch_ready);
    if (!consumers_on) begin
      alu_ready    = 1'b0;
      mem_ready    = 1'b0;
      branch_ready = 1'b0;
    end
  end

  task automatic abort_run(string what);
    $display("Timeout: %s", what);
    $display("*** TEST FAILED ***");
    $finish;
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (exp !== act) begin
      $display("ERROR %s expected %b actual %b", name, exp, act);
      tb_errors++;
    end
  endtask

  task automatic send_random(int count);
    int waited;
    for (int n = 0; n < count; n++) begin
      instr.tag  = next_tag;
      instr.unit = hsv_core_pkg::unit_e'(2'({$random(seed)} % 3));
      if (instr.unit == hsv_core_pkg::UNIT_MEM) instr.op = 3'($random(seed));
      else instr.op = hsv_core_pkg::alu_op_e'(3'({$random(seed)} % 6));
      instr.rs1 = hsv_core_pkg::reg_addr_t'({$random(seed)} % 8);
      instr.rs2 = hsv_core_pkg::reg_addr_t'({$random(seed)} % 8);
      instr.rd  = hsv_core_pkg::reg_addr_t'({$random(seed)} % 8);
      instr.imm = $random(seed);
      valid     = 1'b1;
      next_tag++;
      waited = 0;
      do begin
        @(posedge clk_core);
        waited++;
        if (waited > 2000) abort_run("input channel never accepted an instruction");
      end while (!ready);
      #2;
      valid = ({$random(seed)} % 4) == 0;
      if (valid) begin
        valid = 1'b0;
        @(posedge clk_core);
        #2;
      end
    end
    valid = 1'b0;
  endtask

  task automatic wait_idle(logic need_drain);
    int waited;
    waited = 0;
    while (cq_rd.size() > 0 || commit.valid || (need_drain && pending > 0)) begin
      @(posedge clk_core);
      waited++;
      if (waited > 2000) abort_run("pipeline did not drain");
    end
  endtask

  initial begin
    seed = 44156;
    rst_core_n = 1'b0;
    flush_req = 1'b0;
    valid = 1'b0;
    instr = '0;
    commit = '0;
    alu_ready = 1'b0;
    mem_ready = 1'b0;
    branch_ready = 1'b0;
    consumers_on = 1'b1;
    next_tag = '0;
    tb_errors = 0;
    commit_delay = 0;
    for (int i = 0; i < 32; i++) begin
      committed_val[i] = '0;
    end
    for (int u = 0; u < 3; u++) hold[u] = 0;
    repeat (5) @(posedge clk_core);
    #2 rst_core_n = 1'b1;
    check_bit("reset_alu_valid", 1'b0, alu_valid);
    check_bit("reset_mem_valid", 1'b0, mem_valid);
    check_bit("reset_branch_valid", 1'b0, branch_valid);
    check_bit("reset_ready", 1'b1, ready);
    check_bit("reset_flush_ack", 1'b1, flush_ack);
    send_random(400);
    // Freeze consumers so unconsumed items are the ones that get flushed
    consumers_on = 1'b0;
    repeat (3) @(posedge clk_core);
    wait_idle(1'b0);
    #2 flush_req = 1'b1;
    @(posedge clk_core);
    #1;
    check_bit("flush_alu_valid", 1'b0, alu_valid);
    check_bit("flush_mem_valid", 1'b0, mem_valid);
    check_bit("flush_branch_valid", 1'b0, branch_valid);
    check_bit("flush_ack_high", 1'b1, flush_ack);
    #1 flush_req = 1'b0;
    consumers_on = 1'b1;
    @(posedge clk_core);
    #1 check_bit("flush_ack_low", 1'b0, flush_ack);
    #1 send_random(200);
    wait_idle(1'b1);
    repeat (5) @(posedge clk_core);
    $display("Errors: checker %0d, testbench %0d", chk_errors, tb_errors);
    if (chk_errors == 0 && tb_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- verification/hsv_issue_checker.sv
`timescale 1ns/1ps

module hsv_issue_checker (
  input  logic                       clk_core,
  input  logic                       rst_core_n,
  input  logic                       clear_i,
  input  logic                       alu_push_i,
  input  hsv_core_pkg::alu_data_t    alu_exp_i,
  input  logic                       mem_push_i,
  input  hsv_core_pkg::mem_data_t    mem_exp_i,
  input  logic                       branch_push_i,
  input  hsv_core_pkg::branch_data_t branch_exp_i,
  input  hsv_core_pkg::alu_data_t    alu_data_i,
  input  logic                       alu_valid_i,
  input  logic                       alu_ready_i,
  input  hsv_core_pkg::mem_data_t    mem_data_i,
  input  logic                       mem_valid_i,
  input  logic                       mem_ready_i,
  input  hsv_core_pkg::branch_data_t branch_data_i,
  input  logic                       branch_valid_i,
  input  logic                       branch_ready_i,
  output int                         error_count_o,
  output int                         pending_o
);

  // All three unit items have the same width
  localparam int ITEM_W = $bits(hsv_core_pkg::alu_data_t);

  hsv_core_pkg::alu_data_t    alu_q[$];
  hsv_core_pkg::mem_data_t    mem_q[$];
  hsv_core_pkg::branch_data_t branch_q[$];

  // Held outputs from the previous edge
  logic                       alu_held;
  logic                       mem_held;
  logic                       branch_held;
  hsv_core_pkg::alu_data_t    alu_prev;
  hsv_core_pkg::mem_data_t    mem_prev;
  hsv_core_pkg::branch_data_t branch_prev;

  initial begin
    error_count_o = 0;
    pending_o     = 0;
    alu_held      = 1'b0;
    mem_held      = 1'b0;
    branch_held   = 1'b0;
  end

  task automatic report(string name, logic [ITEM_W-1:0] exp, logic [ITEM_W-1:0] act);
    $display("ERROR %s expected %h actual %h", name, exp, act);
    error_count_o++;
  endtask

  task automatic report_extra(string unit);
    $display("%s unit delivered an item that was never issued", unit);
    error_count_o++;
  endtask

  always @(posedge clk_core) begin
    hsv_core_pkg::alu_data_t    ea;
    hsv_core_pkg::mem_data_t    em;
    hsv_core_pkg::mem_data_t    am;
    hsv_core_pkg::branch_data_t eb;
    if (rst_core_n) begin
      // Data must not move while the consumer holds off
      if (alu_held && alu_valid_i && alu_data_i !== alu_prev)
        report("alu_stable", alu_prev, alu_data_i);
      if (mem_held && mem_valid_i && mem_data_i !== mem_prev)
        report("mem_stable", mem_prev, mem_data_i);
      if (branch_held && branch_valid_i && branch_data_i !== branch_prev)
        report("branch_stable", branch_prev, branch_data_i);
      if (clear_i) begin
        alu_q.delete();
        mem_q.delete();
        branch_q.delete();
      end else begin
        if (alu_valid_i && alu_ready_i) begin
          if (alu_q.size() == 0) begin
            report_extra("alu");
          end else begin
            ea = alu_q.pop_front();
            if (ea !== alu_data_i) report("alu_issue", ea, alu_data_i);
          end
        end
        if (mem_valid_i && mem_ready_i) begin
          if (mem_q.size() == 0) begin
            report_extra("mem");
          end else begin
            em = mem_q.pop_front();
            am = mem_data_i;
            // Store data of a load is don't care
            if (!em.op.is_store) am.store_data = em.store_data;
            if (em !== am) report("mem_issue", em, am);
          end
        end
        if (branch_valid_i && branch_ready_i) begin
          if (branch_q.size() == 0) begin
            report_extra("branch");
          end else begin
            eb = branch_q.pop_front();
            if (eb !== branch_data_i) report("branch_issue", eb, branch_data_i);
          end
        end
      end
      if (alu_push_i) alu_q.push_back(alu_exp_i);
      if (mem_push_i) mem_q.push_back(mem_exp_i);
      if (branch_push_i) branch_q.push_back(branch_exp_i);
    end
    alu_held    = alu_valid_i & ~alu_ready_i;
    mem_held    = mem_valid_i & ~mem_ready_i;
    branch_held = branch_valid_i & ~branch_ready_i;
    alu_prev    = alu_data_i;
    mem_prev    = mem_data_i;
    branch_prev = branch_data_i;
    pending_o   = alu_q.size() + mem_q.size() + branch_q.size();
  end

endmodule

//--- design/hsv_core_issue.sv
`timescale 1ns/1ps

module hsv_core_issue (
  input  logic                       clk_core,
  input  logic                       rst_core_n,

  input  logic                       flush_req_i,
  output logic                       flush_ack_o,

  input  hsv_core_pkg::issue_data_t  issue_data_i,
  input  logic                       valid_i,
  output logic                       ready_o,

  output hsv_core_pkg::alu_data_t    alu_data_o,
  output logic                       alu_valid_o,
  input  logic                       alu_ready_i,

  output hsv_core_pkg::mem_data_t    mem_data_o,
  output logic                       mem_valid_o,
  input  logic                       mem_ready_i,

  output hsv_core_pkg::branch_data_t branch_data_o,
  output logic                       branch_valid_o,
  input  logic                       branch_ready_i,

  input  hsv_core_pkg::commit_t      commit_i
);

  hsv_core_pkg::issue_data_t  hm_data;
  logic                       hm_valid;
  hsv_core_pkg::reg_mask_t    hm_read_mask;
  hsv_core_pkg::reg_mask_t    hm_rd_mask;

  hsv_core_pkg::reg_addr_t    rs1_addr;
  hsv_core_pkg::reg_addr_t    rs2_addr;
  hsv_core_pkg::word_t        rs1_data;
  hsv_core_pkg::word_t        rs2_data;

  hsv_core_pkg::alu_data_t    fork_alu_data;
  hsv_core_pkg::mem_data_t    fork_mem_data;
  hsv_core_pkg::branch_data_t fork_branch_data;
  logic                       fork_alu_valid;
  logic                       fork_mem_valid;
  logic                       fork_branch_valid;

  logic                       alu_buf_ready;
  logic                       mem_buf_ready;
  logic                       branch_buf_ready;

  logic                       hazard;
  logic                       unit_stall;
  logic                       stall;

  // Any full buffer freezes both stages
  assign unit_stall = ~alu_buf_ready | ~mem_buf_ready | ~branch_buf_ready;
  assign stall      = unit_stall | hazard;
  assign ready_o    = ~stall;

  hsv_core_issue_hazardmask u_hazardmask (
    .clk_core     (clk_core),
    .rst_core_n   (rst_core_n),
    .stall_i      (stall),
    .flush_i      (flush_req_i),
    .issue_data_i (issue_data_i),
    .valid_i      (valid_i),
    .issue_data_o (hm_data),
    .valid_o      (hm_valid),
    .read_mask_o  (hm_read_mask),
    .rd_mask_o    (hm_rd_mask)
  );

  // Fork checks its own hazard, so it only needs the back-pressure part
  hsv_core_issue_fork u_fork (
    .clk_core       (clk_core),
    .rst_core_n     (rst_core_n),
    .stall_i        (unit_stall),
    .flush_i        (flush_req_i),
    .issue_data_i   (hm_data),
    .valid_i        (hm_valid),
    .read_mask_i    (hm_read_mask),
    .rd_mask_i      (hm_rd_mask),
    .commit_i       (commit_i),
    .rs1_addr_o     (rs1_addr),
    .rs2_addr_o     (rs2_addr),
    .rs1_data_i     (rs1_data),
    .rs2_data_i     (rs2_data),
    .hazard_o       (hazard),
    .alu_data_o     (fork_alu_data),
    .alu_valid_o    (fork_alu_valid),
    .mem_data_o     (fork_mem_data),
    .mem_valid_o    (fork_mem_valid),
    .branch_data_o  (fork_branch_data),
    .branch_valid_o (fork_branch_valid)
  );

  hsv_core_regfile u_regfile (
    .clk_core   (clk_core),
    .rst_core_n (rst_core_n),
    .commit_i   (commit_i),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  // Fork outputs hold during a unit stall, push only when all buffers can take it
  hs_skid_buffer #(
    .WIDTH ($bits(hsv_core_pkg::alu_data_t))
  ) u_alu_buf (
    .clk_core   (clk_core),
    .rst_core_n (rst_core_n),
    .flush_i    (flush_req_i),
    .data_i     (fork_alu_data),
    .valid_i    (fork_alu_valid & ~unit_stall),
    .ready_o    (alu_buf_ready),
    .data_o     (alu_data_o),
    .valid_o    (alu_valid_o),
    .ready_i    (alu_ready_i)
  );

  hs_skid_buffer #(
    .WIDTH ($bits(hsv_core_pkg::mem_data_t))
  ) u_mem_buf (
    .clk_core   (clk_core),
    .rst_core_n (rst_core_n),
    .flush_i    (flush_req_i),
    .data_i     (fork_mem_data),
    .valid_i    (fork_mem_valid & ~unit_stall),
    .ready_o    (mem_buf_ready),
    .data_o     (mem_data_o),
    .valid_o    (mem_valid_o),
    .ready_i    (mem_ready_i)
  );

  hs_skid_buffer #(
    .WIDTH ($bits(hsv_core_pkg::branch_data_t))
  ) u_branch_buf (
    .clk_core   (clk_core),
    .rst_core_n (rst_core_n),
    .flush_i    (flush_req_i),
    .data_i     (fork_branch_data),
    .valid_i    (fork_branch_valid & ~unit_stall),
    .ready_o    (branch_buf_ready),
    .data_o     (branch_data_o),
    .valid_o    (branch_valid_o),
    .ready_i    (branch_ready_i)
  );

  // Ack comes up out of reset
  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      flush_ack_o <= 1'b1;
    end else begin
      flush_ack_o <= flush_req_i;
    end
  end

endmodule

//--- design/hsv_core_issue_fork.sv
`timescale 1ns/1ps

module hsv_core_issue_fork (
  input  logic                       clk_core,
  input  logic                       rst_core_n,
  input  logic                       stall_i,
  input  logic                       flush_i,
  input  hsv_core_pkg::issue_data_t  issue_data_i,
  input  logic                       valid_i,
  input  hsv_core_pkg::reg_mask_t    read_mask_i,
  input  hsv_core_pkg::reg_mask_t    rd_mask_i,
  input  hsv_core_pkg::commit_t      commit_i,
  output hsv_core_pkg::reg_addr_t    rs1_addr_o,
  output hsv_core_pkg::reg_addr_t    rs2_addr_o,
  input  hsv_core_pkg::word_t        rs1_data_i,
  input  hsv_core_pkg::word_t        rs2_data_i,
  output logic                       hazard_o,
  output hsv_core_pkg::alu_data_t    alu_data_o,
  output logic                       alu_valid_o,
  output hsv_core_pkg::mem_data_t    mem_data_o,
  output logic                       mem_valid_o,
  output hsv_core_pkg::branch_data_t branch_data_o,
  output logic                       branch_valid_o
);

  hsv_core_pkg::reg_mask_t      pending_q;
  hsv_core_pkg::reg_mask_t      pending_set;
  hsv_core_pkg::reg_mask_t      pending_clr;
  logic                         issue;
  logic                         to_alu;
  logic                         to_mem;
  logic                         to_branch;
  hsv_core_pkg::alu_data_t      alu_next;
  hsv_core_pkg::mem_data_t      mem_next;
  hsv_core_pkg::branch_data_t   branch_next;

  assign rs1_addr_o = issue_data_i.rs1;
  assign rs2_addr_o = issue_data_i.rs2;

  // RAW on the sources, WAW on the destination
  assign hazard_o = valid_i & (|((read_mask_i | rd_mask_i) & pending_q));
  assign issue    = valid_i & ~hazard_o & ~stall_i;

  assign to_alu    = issue & (issue_data_i.unit == hsv_core_pkg::UNIT_ALU);
  assign to_mem    = issue & (issue_data_i.unit == hsv_core_pkg::UNIT_MEM);
  assign to_branch = issue & (issue_data_i.unit == hsv_core_pkg::UNIT_BRANCH);

  // Writer is marked as it enters the fork register, so the next one sees it
  assign pending_set = issue ? rd_mask_i : '0;
  assign pending_clr = commit_i.valid ? hsv_core_pkg::reg_onehot(commit_i.rd) : '0;

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      pending_q <= '0;
    end else if (flush_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= (pending_q & ~pending_clr) | pending_set;
    end
  end

  always_comb begin
    alu_next.tag     = issue_data_i.tag;
    alu_next.op      = issue_data_i.op.alu;
    alu_next.rd      = issue_data_i.rd;
    alu_next.rs1_val = rs1_data_i;
    alu_next.rs2_val = rs2_data_i;
    alu_next.imm     = issue_data_i.imm;

    mem_next.tag        = issue_data_i.tag;
    mem_next.op         = issue_data_i.op.mem;
    mem_next.rd         = issue_data_i.rd;
    mem_next.base       = rs1_data_i;
    mem_next.store_data = rs2_data_i;
    mem_next.imm        = issue_data_i.imm;

    // Compare kind comes through the ALU view
    branch_next.tag     = issue_data_i.tag;
    branch_next.cmp     = issue_data_i.op.alu;
    branch_next.rd      = issue_data_i.rd;
    branch_next.rs1_val = rs1_data_i;
    branch_next.rs2_val = rs2_data_i;
    branch_next.imm     = issue_data_i.imm;
  end

  // A hazard without back-pressure leaves a bubble here
  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      alu_valid_o    <= 1'b0;
      mem_valid_o    <= 1'b0;
      branch_valid_o <= 1'b0;
    end else if (flush_i) begin
      alu_valid_o    <= 1'b0;
      mem_valid_o    <= 1'b0;
      branch_valid_o <= 1'b0;
    end else if (!stall_i) begin
      alu_valid_o    <= to_alu;
      mem_valid_o    <= to_mem;
      branch_valid_o <= to_branch;
    end
  end

  always_ff @(posedge clk_core) begin
    if (to_alu) begin
      alu_data_o <= alu_next;
    end
    if (to_mem) begin
      mem_data_o <= mem_next;
    end
    if (to_branch) begin
      branch_data_o <= branch_next;
    end
  end

endmodule

//--- design/hsv_core_issue_hazardmask.sv
`timescale 1ns/1ps

module hsv_core_issue_hazardmask (
  input  logic                      clk_core,
  input  logic                      rst_core_n,
  input  logic                      stall_i,
  input  logic                      flush_i,
  input  hsv_core_pkg::issue_data_t issue_data_i,
  input  logic                      valid_i,
  output hsv_core_pkg::issue_data_t issue_data_o,
  output logic                      valid_o,
  output hsv_core_pkg::reg_mask_t   read_mask_o,
  output hsv_core_pkg::reg_mask_t   rd_mask_o
);

  logic                    reads_rs2;
  hsv_core_pkg::reg_mask_t read_mask;
  hsv_core_pkg::reg_mask_t rd_mask;

  // Loads only read the base register
  always_comb begin
    case (issue_data_i.unit)
      hsv_core_pkg::UNIT_MEM: reads_rs2 = issue_data_i.op.mem.is_store;
      default:                reads_rs2 = 1'b1;
    endcase
  end

  always_comb begin
    read_mask = hsv_core_pkg::reg_onehot(issue_data_i.rs1);
    if (reads_rs2) begin
      read_mask = read_mask | hsv_core_pkg::reg_onehot(issue_data_i.rs2);
    end
    rd_mask = hsv_core_pkg::reg_onehot(issue_data_i.rd);
  end

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      valid_o <= 1'b0;
    end else if (flush_i) begin
      valid_o <= 1'b0;
    end else if (!stall_i) begin
      valid_o <= valid_i;
    end
  end

  // Instruction and masks stay put while the stage is stalled
  always_ff @(posedge clk_core) begin
    if (!stall_i) begin
      issue_data_o <= issue_data_i;
      read_mask_o  <= read_mask;
      rd_mask_o    <= rd_mask;
    end
  end

endmodule

//--- design/hsv_core_regfile.sv
`timescale 1ns/1ps

`include "hsv_core_macros.svh"

module hsv_core_regfile (
  input  logic                    clk_core,
  input  logic                    rst_core_n,
  input  hsv_core_pkg::commit_t   commit_i,
  input  hsv_core_pkg::reg_addr_t rs1_addr_i,
  input  hsv_core_pkg::reg_addr_t rs2_addr_i,
  output hsv_core_pkg::word_t     rs1_data_o,
  output hsv_core_pkg::word_t     rs2_data_o
);

  hsv_core_pkg::word_t regs_q [`HSV_NREGS];

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      for (int i = 0; i < `HSV_NREGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (commit_i.valid && (commit_i.rd != '0)) begin
      regs_q[commit_i.rd] <= commit_i.data;
    end
  end

  // No bypass of a same-cycle commit
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

endmodule

//--- design/hs_skid_buffer.sv
`timescale 1ns/1ps

module hs_skid_buffer #(
  parameter int WIDTH = 32
) (
  input  logic             clk_core,
  input  logic             rst_core_n,
  input  logic             flush_i,
  input  logic [WIDTH-1:0] data_i,
  input  logic             valid_i,
  output logic             ready_o,
  output logic [WIDTH-1:0] data_o,
  output logic             valid_o,
  input  logic             ready_i
);

  logic [WIDTH-1:0] skid_data_q;
  logic             skid_valid_q;
  logic             push;
  logic             out_free;

  // Ready depends on state only, no path from ready_i
  assign ready_o  = ~(valid_o & skid_valid_q);
  assign push     = valid_i & ready_o;
  assign out_free = ~valid_o | ready_i;

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      valid_o      <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_o      <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (out_free) begin
      // Older skid entry moves forward first
      valid_o      <= skid_valid_q | push;
      skid_valid_q <= skid_valid_q & push;
    end else if (push) begin
      skid_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_core) begin
    if (out_free) begin
      if (skid_valid_q) begin
        data_o <= skid_data_q;
        if (push) begin
          skid_data_q <= data_i;
        end
      end else if (push) begin
        data_o <= data_i;
      end
    end else if (push) begin
      skid_data_q <= data_i;
    end
  end

endmodule

//--- design/hsv_core_pkg.sv
`include "hsv_core_macros.svh"

package hsv_core_pkg;

  typedef logic [`HSV_XLEN-1:0]   word_t;
  typedef logic [`HSV_REG_AW-1:0] reg_addr_t;
  typedef logic [`HSV_NREGS-1:0]  reg_mask_t;
  typedef logic [`HSV_TAG_W-1:0]  tag_t;

  typedef enum logic [1:0] {
    UNIT_ALU    = 2'd0,
    UNIT_MEM    = 2'd1,
    UNIT_BRANCH = 2'd2
  } unit_e;

  // Branch reuses this encoding as its compare kind
  typedef enum logic [2:0] {
    ADD = 3'd0,
    SUB = 3'd1,
    AND = 3'd2,
    OR  = 3'd3,
    XOR = 3'd4,
    SLT = 3'd5
  } alu_op_e;

  typedef struct packed {
    logic       is_store;
    logic [1:0] size;
  } mem_op_t;

  // Same three bits, meaning depends on the unit field
  typedef union packed {
    alu_op_e alu;
    mem_op_t mem;
  } op_u;

  typedef struct packed {
    tag_t      tag;
    unit_e     unit;
    op_u       op;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm;
  } issue_data_t;

  typedef struct packed {
    tag_t      tag;
    alu_op_e   op;
    reg_addr_t rd;
    word_t     rs1_val;
    word_t     rs2_val;
    word_t     imm;
  } alu_data_t;

  typedef struct packed {
    tag_t      tag;
    mem_op_t   op;
    reg_addr_t rd;
    word_t     base;
    word_t     store_data;
    word_t     imm;
  } mem_data_t;

  typedef struct packed {
    tag_t      tag;
    alu_op_e   cmp;
    reg_addr_t rd;
    word_t     rs1_val;
    word_t     rs2_val;
    word_t     imm;
  } branch_data_t;

  typedef struct packed {
    logic      valid;
    reg_addr_t rd;
    word_t     data;
  } commit_t;

  // One-hot register mask, x0 maps to an empty mask
  function automatic reg_mask_t reg_onehot(reg_addr_t addr);
    reg_mask_t mask;
    mask = '0;
    if (addr != '0) begin
      mask[addr] = 1'b1;
    end
    return mask;
  endfunction

endpackage

//--- design/hsv_core_macros.svh
`ifndef HSV_CORE_MACROS_SVH
`define HSV_CORE_MACROS_SVH

// Data path width
`define HSV_XLEN 32

// Architectural register file
`define HSV_NREGS 32
`define HSV_REG_AW 5

// Tag carried with every instruction for tracking
`define HSV_TAG_W 8

`endif
